// File: hdl/elev_cfg_pkg.sv
package elev_cfg_pkg;

	// building size
	localparam int NUM_FLOORS = 4;
	localparam int NUM_CARS = 2;

	// clock cycles of travel for one floor step
	localparam int FLOOR_TICKS = 6;

	// shortest door interval in clock cycles
	localparam int DOOR_TICKS = 30;

	// counter widths for the two timers
	localparam int TRAVEL_CNT_W = $clog2(FLOOR_TICKS);
	localparam int DOOR_CNT_W = $clog2(DOOR_TICKS);

endpackage

// File: hdl/elev_car_pkg.sv
package elev_car_pkg;

	// floor number, 0 is the ground floor
	typedef logic [$clog2(elev_cfg_pkg::NUM_FLOORS)-1:0] floor_t;

	// one bit per floor, bit n is floor n
	typedef logic [elev_cfg_pkg::NUM_FLOORS-1:0] floor_mask_t;

	// car sequencing states
	typedef enum logic [1:0] {
		IDLE,
		MOVE_UP,
		MOVE_DOWN,
		DOOR_OPEN
	} car_state_t;

	// travel command to the motion block
	typedef enum logic [1:0] {
		NONE = 2'b00,
		UP   = 2'b01,
		DOWN = 2'b10
	} dir_t;

endpackage

// File: hdl/car_dispatch_if.sv
interface car_dispatch_if;
	import elev_car_pkg::*;

	// four-phase handshake, req from the dispatcher, ack from the car
	logic req;
	logic ack;

	// target floor, held stable while req is high
	floor_t dest;

	// where the car is right now
	floor_t cur_floor;

	modport dispatch (
		output req,
		output dest,
		input  ack,
		input  cur_floor
	);

	modport car (
		input  req,
		input  dest,
		output ack,
		output cur_floor
	);

	// read-only view for the call latches
	modport monitor (
		input ack,
		input cur_floor
	);

endinterface

// File: hdl/call_register_bank.sv
module call_register_bank (
	input  logic                      clock,
	input  logic                      reset,
	input  elev_car_pkg::floor_mask_t hall_call,
	car_dispatch_if.monitor           car0,
	car_dispatch_if.monitor           car1,
	output elev_car_pkg::floor_mask_t pending
);
	import elev_cfg_pkg::*;
	import elev_car_pkg::*;

	// floors where some car has its door open this cycle
	floor_mask_t served;

	always_comb
	begin
		for (int f = 0; f < NUM_FLOORS; f++)
		begin
			served[f] = (car0.ack && car0.cur_floor == floor_t'(f)) ||
				(car1.ack && car1.cur_floor == floor_t'(f));
		end
	end

	// a clear beats a set in the same cycle
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			pending <= '0;
		end
		else
		begin
			pending <= (pending | hall_call) & ~served;
		end
	end

	// a latched call only goes away once a door has opened at its floor
	a_clear_needs_door: assert property (
		@(posedge clock) disable iff (reset)
		(($past(pending) & ~pending) & ~$past(served)) == '0
	);

endmodule

// File: hdl/dispatcher.sv
module dispatcher (
	input  logic                      clock,
	input  logic                      reset,
	input  elev_car_pkg::floor_mask_t pending,
	car_dispatch_if.dispatch          car0,
	car_dispatch_if.dispatch          car1
);
	import elev_cfg_pkg::*;
	import elev_car_pkg::*;

	logic [NUM_CARS-1:0] req_q;
	logic [NUM_CARS-1:0] ack_in;
	logic [NUM_CARS-1:0] free;
	logic [NUM_CARS-1:0] grant;
	floor_t dest_q [NUM_CARS];
	floor_t cur_in [NUM_CARS];

	// chosen call for this cycle
	logic found;
	floor_t target;

	function automatic floor_t distance(floor_t a, floor_t b);
		return (a > b) ? floor_t'(a - b) : floor_t'(b - a);
	endfunction

	// gather both cars into arrays
	assign ack_in[0] = car0.ack;
	assign ack_in[1] = car1.ack;
	assign cur_in[0] = car0.cur_floor;
	assign cur_in[1] = car1.cur_floor;

	assign car0.req = req_q[0];
	assign car1.req = req_q[1];
	assign car0.dest = dest_q[0];
	assign car1.dest = dest_q[1];

	assign free = ~(req_q | ack_in);

	// lowest pending floor that no busy car is already heading for
	always_comb
	begin
		found = 1'b0;
		target = '0;
		for (int f = 0; f < NUM_FLOORS; f++)
		begin
			if (pending[f] && !found &&
				!(!free[0] && dest_q[0] == floor_t'(f)) &&
				!(!free[1] && dest_q[1] == floor_t'(f)))
			begin
				found = 1'b1;
				target = floor_t'(f);
			end
		end
	end

	// nearer free car wins, car 0 on a tie
	always_comb
	begin
		grant = '0;
		if (found)
		begin
			if (free[0] && (!free[1] ||
				distance(cur_in[0], target) <= distance(cur_in[1], target)))
			begin
				grant[0] = 1'b1;
			end
			else if (free[1])
			begin
				grant[1] = 1'b1;
			end
		end
	end

	// req rises only from idle handshake, falls once ack is seen
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			req_q <= '0;
		end
		else
		begin
			for (int c = 0; c < NUM_CARS; c++)
			begin
				if (req_q[c] && ack_in[c])
					req_q[c] <= 1'b0;
				else if (grant[c])
					req_q[c] <= 1'b1;
			end
		end
	end

	always_ff @(posedge clock)
	begin
		for (int c = 0; c < NUM_CARS; c++)
		begin
			if (grant[c])
				dest_q[c] <= target;
		end
	end

	// req must not be withdrawn before the car has answered
	for (genvar c = 0; c < NUM_CARS; c++)
	begin : g_handshake
		a_req_held: assert property (
			@(posedge clock) disable iff (reset)
			$fell(req_q[c]) |-> $past(ack_in[c])
		);
	end

endmodule

// File: hdl/car_motion.sv
module car_motion (
	input  logic                 clock,
	input  logic                 reset,
	input  elev_car_pkg::dir_t   dir,
	output elev_car_pkg::floor_t floor
);
	import elev_cfg_pkg::*;
	import elev_car_pkg::*;

	logic [TRAVEL_CNT_W-1:0] tick_cnt;
	logic step;

	// one floor step per FLOOR_TICKS cycles of travel
	assign step = (dir != NONE) && (tick_cnt == TRAVEL_CNT_W'(FLOOR_TICKS - 1));

	always_ff @(posedge clock)
	begin
		if (reset)
			tick_cnt <= '0;
		else if (dir == NONE || step)
			tick_cnt <= '0;
		else
			tick_cnt <= tick_cnt + 1'b1;
	end

	// saturating position counter
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			floor <= '0;
		end
		else if (step)
		begin
			if (dir == UP && floor != floor_t'(NUM_FLOORS - 1))
				floor <= floor + 1'b1;
			else if (dir == DOWN && floor != '0)
				floor <= floor - 1'b1;
		end
	end

	a_single_step: assert property (
		@(posedge clock) disable iff (reset)
		(int'(floor) - int'($past(floor))) inside {-1, 0, 1}
	);

endmodule

// File: hdl/car_controller.sv
module car_controller (
	input  logic        clock,
	input  logic        reset,
	car_dispatch_if.car bus
);
	import elev_cfg_pkg::*;
	import elev_car_pkg::*;

	car_state_t state;
	car_state_t state_next;
	dir_t dir;
	logic [DOOR_CNT_W-1:0] door_cnt;
	logic door_done;

	car_motion u_motion (
		.clock (clock),
		.reset (reset),
		.dir   (dir),
		.floor (bus.cur_floor)
	);

	assign door_done = (door_cnt == DOOR_CNT_W'(DOOR_TICKS - 1));

	// door open is the acknowledge
	assign bus.ack = (state == DOOR_OPEN);

	always_comb
	begin
		state_next = state;
		case (state)
			IDLE:
			begin
				if (bus.req)
				begin
					if (bus.dest == bus.cur_floor)
						state_next = DOOR_OPEN;
					else if (bus.dest > bus.cur_floor)
						state_next = MOVE_UP;
					else
						state_next = MOVE_DOWN;
				end
			end
			MOVE_UP, MOVE_DOWN:
			begin
				if (bus.cur_floor == bus.dest)
					state_next = DOOR_OPEN;
			end
			DOOR_OPEN:
			begin
				// a late req drop keeps the door open
				if (door_done && !bus.req)
					state_next = IDLE;
			end
			default:
			begin
				state_next = IDLE;
			end
		endcase
	end

	// stop commanding motion as soon as the car arrives
	always_comb
	begin
		dir = NONE;
		if (state == MOVE_UP && bus.cur_floor != bus.dest)
			dir = UP;
		else if (state == MOVE_DOWN && bus.cur_floor != bus.dest)
			dir = DOWN;
	end

	always_ff @(posedge clock)
	begin
		if (reset)
			state <= IDLE;
		else
			state <= state_next;
	end

	// door timer, saturates at the minimum interval
	always_ff @(posedge clock)
	begin
		if (reset)
			door_cnt <= '0;
		else if (state != DOOR_OPEN)
			door_cnt <= '0;
		else if (!door_done)
			door_cnt <= door_cnt + 1'b1;
	end

	a_still_at_door: assert property (
		@(posedge clock) disable iff (reset)
		bus.ack |-> dir == NONE
	);

endmodule

// File: hdl/elev_top.sv
module elev_top (
	input  logic                      clock,
	input  logic                      reset,
	input  elev_car_pkg::floor_mask_t hall_call,
	output elev_car_pkg::floor_mask_t call_pending,
	output elev_car_pkg::floor_t      car0_floor,
	output elev_car_pkg::floor_t      car1_floor,
	output logic                      car0_door_open,
	output logic                      car1_door_open
);

	// one handshake link per car
	car_dispatch_if car0_bus ();
	car_dispatch_if car1_bus ();

	call_register_bank u_bank (
		.clock     (clock),
		.reset     (reset),
		.hall_call (hall_call),
		.car0      (car0_bus),
		.car1      (car1_bus),
		.pending   (call_pending)
	);

	dispatcher u_dispatch (
		.clock   (clock),
		.reset   (reset),
		.pending (call_pending),
		.car0    (car0_bus),
		.car1    (car1_bus)
	);

	car_controller u_car0 (
		.clock (clock),
		.reset (reset),
		.bus   (car0_bus)
	);

	car_controller u_car1 (
		.clock (clock),
		.reset (reset),
		.bus   (car1_bus)
	);

	assign car0_floor = car0_bus.cur_floor;
	assign car1_floor = car1_bus.cur_floor;

	// ack is high for exactly the door-open interval
	assign car0_door_open = car0_bus.ack;
	assign car1_door_open = car1_bus.ack;

endmodule

// File: sim/elev_tb.sv
module elev_tb;
	timeunit 1ns;
	timeprecision 1ps;

	import elev_cfg_pkg::*;
	import elev_car_pkg::*;

	localparam int NUM_TESTS = 6;
	localparam int CALL_BOUND = 3 * FLOOR_TICKS + DOOR_TICKS + 20;
	localparam int WATCHDOG_CYCLES = NUM_TESTS * CALL_BOUND * 4;
	localparam int RANDOM_CALLS = 8;

	logic clock;
	logic reset;
	floor_mask_t hall_call;
	floor_mask_t call_pending;
	floor_t car0_floor;
	floor_t car1_floor;
	logic car0_door_open;
	logic car1_door_open;

	// per-car views of the outputs
	floor_t car_floor [NUM_CARS];
	floor_t prev_floor [NUM_CARS];
	logic [NUM_CARS-1:0] door;
	int open_cycles [NUM_CARS];
	int floor_moves [NUM_CARS];
	floor_mask_t served_mask;

	string test_name;
	int error_count;
	int errors_at_start;
	int pass_count;
	int fail_count;
	logic [31:0] rng_state;

	elev_top dut (
		.clock          (clock),
		.reset          (reset),
		.hall_call      (hall_call),
		.call_pending   (call_pending),
		.car0_floor     (car0_floor),
		.car1_floor     (car1_floor),
		.car0_door_open (car0_door_open),
		.car1_door_open (car1_door_open)
	);

	always #4 clock = ~clock;

	assign car_floor[0] = car0_floor;
	assign car_floor[1] = car1_floor;
	assign door = {car1_door_open, car0_door_open};

	// floors with an open door right now
	always_comb
	begin
		for (int f = 0; f < NUM_FLOORS; f++)
			served_mask[f] = (door[0] && car_floor[0] == floor_t'(f)) ||
				(door[1] && car_floor[1] == floor_t'(f));
	end

	// last floor, floor step count and length of the current door interval
	always @(posedge clock)
	begin
		for (int c = 0; c < NUM_CARS; c++)
		begin
			prev_floor[c] <= car_floor[c];
			open_cycles[c] <= (reset || !door[c]) ? 0 : open_cycles[c] + 1;
			if (!reset && car_floor[c] != prev_floor[c])
				floor_moves[c] <= floor_moves[c] + 1;
		end
	end

	function automatic int floor_gap(floor_t a, floor_t b);
		return (a > b) ? int'(a) - int'(b) : int'(b) - int'(a);
	endfunction

	function automatic logic [31:0] next_random();
		logic [31:0] x;
		x = rng_state;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		rng_state = x;
		return x;
	endfunction

	task automatic value_mismatch(input string what, input int expected, input int actual);
		error_count++;
		$display("Mismatch %s: %s expected %0d actual %0d", test_name, what, expected, actual);
	endtask

	task automatic start_test(input string name);
		test_name = name;
		errors_at_start = error_count;
	endtask

	task automatic finish_test();
		if (error_count == errors_at_start)
		begin
			pass_count++;
			$display("%s: ok", test_name);
		end
		else
		begin
			fail_count++;
			$display("%s: %0d errors", test_name, error_count - errors_at_start);
		end
	endtask

	// one-cycle pulse on a hall button
	task automatic press_call(input floor_t f);
		hall_call[f] = 1'b1;
		@(posedge clock);
		#1;
		hall_call = '0;
	endtask

	task automatic wait_door(input floor_t f, output int car);
		int cycles;
		car = -1;
		cycles = 0;
		while (car < 0 && cycles < CALL_BOUND)
		begin
			@(posedge clock);
			#1;
			cycles++;
			for (int c = 0; c < NUM_CARS; c++)
				if (car < 0 && door[c] && car_floor[c] == f)
					car = c;
		end
		if (car < 0)
		begin
			error_count++;
			$display("%s: no door opened at floor %0d in %0d cycles", test_name, f, cycles);
		end
	endtask

	// all calls served and both doors closed
	task automatic wait_quiet(input int limit);
		int cycles;
		cycles = 0;
		while ((call_pending != '0 || door != '0) && cycles < limit)
		begin
			@(posedge clock);
			#1;
			cycles++;
		end
		if (call_pending != '0 || door != '0)
		begin
			error_count++;
			$display("%s: calls still open after %0d cycles", test_name, limit);
		end
	endtask

	reset_values: assert property (@(posedge clock)
		$fell(reset) |-> {call_pending, door, car_floor[0], car_floor[1]} == '0)
		else value_mismatch("pending, doors and floors", 0,
			int'($sampled({call_pending, door, car_floor[0], car_floor[1]})));

	for (genvar f = 0; f < NUM_FLOORS; f++)
	begin : g_floor
		call_latched: assert property (@(posedge clock) disable iff (reset)
			(hall_call[f] || call_pending[f]) && !served_mask[f] |=> call_pending[f])
			else value_mismatch($sformatf("call_pending[%0d]", f), 1, 0);
		call_cleared: assert property (@(posedge clock) disable iff (reset)
			served_mask[f] |=> !call_pending[f])
			else value_mismatch($sformatf("call_pending[%0d]", f), 0, 1);
	end

	for (genvar c = 0; c < NUM_CARS; c++)
	begin : g_car
		parked_at_door: assert property (@(posedge clock) disable iff (reset)
			$past(door[c]) |-> car_floor[c] == prev_floor[c])
			else value_mismatch($sformatf("car %0d floor", c),
				$sampled(prev_floor[c]), $sampled(car_floor[c]));
		single_step: assert property (@(posedge clock) disable iff (reset)
			floor_gap(car_floor[c], prev_floor[c]) <= 1)
			else value_mismatch($sformatf("car %0d floor step", c), 1,
				floor_gap($sampled(car_floor[c]), $sampled(prev_floor[c])));
		door_interval: assert property (@(posedge clock) disable iff (reset)
			$fell(door[c]) |-> open_cycles[c] >= DOOR_TICKS)
			else value_mismatch($sformatf("car %0d door cycles", c), DOOR_TICKS,
				$sampled(open_cycles[c]));
	end

	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge clock);
		$display("watchdog expired after %0d cycles", WATCHDOG_CYCLES);
		$display("TEST FAILED");
		$finish;
	end

	initial
	begin
		int car;
		int gap;
		int start_moves;
		floor_t start_floor;
		clock = 1'b0;
		reset = 1'b1;
		hall_call = '0;
		error_count = 0;
		pass_count = 0;
		fail_count = 0;
		rng_state = 32'h146f;
		test_name = "reset";
		repeat (8) @(posedge clock);
		#1;
		reset = 1'b0;

		start_test("reset_state");
		@(posedge clock);
		#1;
		finish_test();

		// both cars start on floor 0 so the tie goes to car 0
		start_test("tie_call");
		press_call(2'd2);
		wait_door(2'd2, car);
		assert (car < 0 || car == 0) else value_mismatch("serving car", 0, car);
		@(posedge clock);
		#1;
		assert (call_pending[2] == 1'b0) else value_mismatch("call_pending[2]", 0, 1);
		wait_quiet(CALL_BOUND);
		finish_test();

		start_test("call_latch");
		press_call(2'd1);
		assert (call_pending[1] == 1'b1) else value_mismatch("call_pending[1]", 1, 0);
		wait_door(2'd1, car);
		wait_quiet(CALL_BOUND);
		finish_test();

		// car 0 takes floor 2 and still holds req when floor 3 is called
		start_test("busy_car0");
		press_call(2'd2);
		@(posedge clock);
		#1;
		press_call(2'd3);
		wait_door(2'd3, car);
		assert (car < 0 || car == 1) else value_mismatch("serving car", 1, car);
		wait_quiet(CALL_BOUND);
		finish_test();

		start_test("same_floor");
		start_floor = car_floor[0];
		start_moves = floor_moves[0];
		press_call(start_floor);
		wait_door(start_floor, car);
		assert (car < 0 || car == 0) else value_mismatch("serving car", 0, car);
		assert (floor_moves[0] == start_moves)
			else value_mismatch("car 0 floor steps", 0, floor_moves[0] - start_moves);
		wait_quiet(CALL_BOUND);
		finish_test();

		start_test("random_pass");
		for (int i = 0; i < RANDOM_CALLS; i++)
		begin
			press_call(floor_t'(next_random() % NUM_FLOORS));
			gap = int'(next_random() % 12);
			repeat (gap)
			begin
				@(posedge clock);
				#1;
			end
		end
		wait_quiet(RANDOM_CALLS * CALL_BOUND);
		finish_test();

		repeat (2) @(posedge clock);
		$display("%0d tests ok, %0d tests with errors", pass_count, fail_count);
		if (fail_count == 0 && error_count == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// File: list.f
hdl/elev_cfg_pkg.sv
hdl/elev_car_pkg.sv
hdl/car_dispatch_if.sv
hdl/call_register_bank.sv
hdl/dispatcher.sv
hdl/car_motion.sv
hdl/car_controller.sv
hdl/elev_top.sv
sim/elev_tb.sv

// File: Bender.yml
package:
  name: elev

sources:
  - hdl/elev_cfg_pkg.sv
  - hdl/elev_car_pkg.sv
  - hdl/car_dispatch_if.sv
  - hdl/call_register_bank.sv
  - hdl/dispatcher.sv
  - hdl/car_motion.sv
  - hdl/car_controller.sv
  - hdl/elev_top.sv
  - target: simulation
    files:
      - sim/elev_tb.sv
